// File: tests/soc_trace.txt
# one command per line, all numbers in hex
# W addr data sel | R addr expected | G gp_value | S warm or poweroff | I idle_cycles
R 0 4
R 1 7
R 2 40
R 3 80000006
R 4 4
R 5 1
R 6 100
R 7 0
R 8 400
R 9 0
W 40 a5 1
R 40 a5
G 3c
I 3
R 41 3c
W 44 11223344 f
W 44 aabbccdd 5
R 44 11bb33dd
W 45 0 f
W 45 deadbeef c
R 45 dead0000
W 144 ffffffff f
R 144 0
R 44 11bb33dd
I 82
R 0 4
S warm
R 40 0
R 44 11bb33dd
W 40 ff 1
S poweroff
R 40 0
R 45 dead0000

// File: sim.f
+incdir+tests
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
hdl/bus_decoder.sv
sysctl/dev_table.sv
sysctl/reset_seq.sv
hdl/gpio_port.sv
hdl/scratch_ram.sv
hdl/activity_led.sv
hdl/soc_top.sv
tests/soc_tb.sv

// File: tests/bus_tasks.svh
/*
 * Bus master tasks, random idle source and the value checker for the testbench.
 */

// taps 32, 22, 2, 1, the new bit enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic stop_run(input string msg);
	$display("%s", msg);
	$display("TEST RESULT: FAIL");
	$fatal(1, "simulation stopped on the first error");
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp)
		stop_run($sformatf("Mismatch at time %0t: %s, got %h, expected %h",
			$time, what, got, exp));
endtask

// called on a falling edge, returns on the falling edge after the rdy cycle
task automatic run_access(input bus_op_e op, input bus_addr_t addr, input bus_data_t wdata,
		input bus_sel_t sel, output bus_data_t rdata);
	int idle;
	int n;
	int exp_n;
	lfsr = lfsr_next(lfsr);
	idle = lfsr[0];
	lfsr = lfsr_next(lfsr);
	idle = idle * 2 + lfsr[0];
	repeat (idle) @(negedge clk_w);

	pi1_op_i = op;
	pi1_addr_i = addr;
	pi1_data_i = wdata;
	pi1_sel_i = sel;

	// unmapped words answer in the op cycle, register slaves one cycle later
	exp_n = (addr >= MAP_END_W) ? 1 : 2;
	n = 1;
	#1;
	while (pi1_rdy_o !== 1'b1) begin
		if (n >= 8)
			stop_run($sformatf("bus access to word %h never got rdy", addr));
		@(negedge clk_w);
		#1;
		n++;
	end
	rdy_cyc = cyc;
	rdata = pi1_data_o;
	check_value(n, exp_n, $sformatf("cycles from op to rdy at word %h", addr));

	@(negedge clk_w);
	pi1_op_i = OP_NOP;
	pi1_sel_i = '0;
endtask

// File: tests/soc_tb.sv
/*
 * System-control testbench: replays the trace against the top level and
 * watches the reset timing, the GPIO pins and the activity indicator.
 */
`timescale 1ns/1ps

module soc_tb;

	import soc_bus_pkg::*;

	localparam int RST_BITS = 4;
	localparam int RST_MIN = 2 ** RST_BITS - 1;
	localparam int RST_MAX = 2 ** RST_BITS + 3;
	// hold-off of a 7-bit dimmer counter
	localparam int HOLD_CYCLES = 128;
	localparam int GPIO_BASE = 64;
	localparam int MAP_END_W = 324;

	logic clk_w = 1'b0;
	logic rst_p;
	bus_op_e pi1_op_i;
	bus_addr_t pi1_addr_i;
	bus_data_t pi1_data_i;
	bus_sel_t pi1_sel_i;
	bus_data_t pi1_data_o;
	logic pi1_rdy_o;
	logic [7:0] gp_i;
	logic [7:1] gp_o;
	logic sys_rst_o;
	logic activity_o;

	int cyc = 0;
	int limit = 0;
	int rdy_cyc = -10;
	int last_pulse = -1000;
	logic mon_en = 1'b0;
	logic prev_rst = 1'b0;
	logic pulse_due;
	logic [31:0] lfsr = 32'h04cc54fb;
	logic [7:0] gp_model = '0;
	string lines [$];

	`include "bus_tasks.svh"

	soc_top #(
		.GPIOCOUNT(8),
		.RST_CNTR_BITSZ(RST_BITS),
		.ACTIVITY_CNTR_BITSZ(7)
	) dut0 (
		.clk_w(clk_w),
		.rst_p(rst_p),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o),
		.gp_i(gp_i),
		.gp_o(gp_o),
		.sys_rst_o(sys_rst_o),
		.activity_o(activity_o)
	);

	always #10 clk_w = ~clk_w;

	always @(posedge clk_w) begin
		cyc = cyc + 1;
		if (limit > 0 && cyc > limit)
			stop_run($sformatf("run did not finish within %0d cycles", limit));
	end

	// a transfer blinks the LED in the next cycle unless a pulse came too recently
	always @(negedge clk_w) begin
		if (mon_en) begin
			if (sys_rst_o && prev_rst) begin
				check_value(activity_o, 1'b0, "activity_o during reset");
				check_value(gp_o, '0, "gp_o during reset");
				last_pulse = -1000;
			end else begin
				pulse_due = (rdy_cyc == cyc - 1) && (cyc - last_pulse >= HOLD_CYCLES);
				check_value(activity_o, pulse_due, "activity_o");
				if (activity_o)
					last_pulse = cyc;
			end
			prev_rst = sys_rst_o;
		end
	end

	task automatic wait_reset_release(input string what);
		int n;
		n = 0;
		while (sys_rst_o !== 1'b0) begin
			@(negedge clk_w);
			n++;
		end
		if (n < RST_MIN || n > RST_MAX)
			stop_run($sformatf("%s held sys_rst_o for %0d cycles, outside %0d to %0d",
				what, n, RST_MIN, RST_MAX));
	endtask

	initial begin : main
		int fd;
		string line;
		string cmd;
		string kind;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] s;
		bus_data_t rd;
		rst_p = 1'b1;
		pi1_op_i = OP_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		gp_i = '0;

		fd = $fopen("tests/soc_trace.txt", "r");
		if (fd == 0)
			stop_run("could not open the trace file tests/soc_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		limit = lines.size() * 16 + 8 * (2 ** RST_BITS) + 200;

		repeat (3) @(negedge clk_w);
		rst_p = 1'b0;
		wait_reset_release("rst_p");
		mon_en = 1'b1;

		foreach (lines[i]) begin
			a = '0;
			void'($sscanf(lines[i], "%s", cmd));
			case (cmd)
				"W": begin
					void'($sscanf(lines[i], "%s %h %h %h", cmd, a, d, s));
					run_access(OP_WRITE, a[29:0], d, s[3:0], rd);
					if (a == GPIO_BASE) begin
						if (s[0])
							gp_model = d[7:0];
						check_value(gp_o, gp_model[7:1], "gp_o after GPIO write");
					end
				end
				"R": begin
					void'($sscanf(lines[i], "%s %h %h", cmd, a, d));
					run_access(OP_READ, a[29:0], '0, '0, rd);
					check_value(rd, d, $sformatf("read of word %h", a));
				end
				"G": begin
					void'($sscanf(lines[i], "%s %h", cmd, a));
					gp_i = a[7:0];
				end
				"I": begin
					void'($sscanf(lines[i], "%s %h", cmd, a));
					repeat (a) @(negedge clk_w);
				end
				"S": begin
					void'($sscanf(lines[i], "%s %s", cmd, kind));
					if (kind == "warm") begin
						run_access(OP_WRITE, '0, 32'd2, 4'hf, rd);
						wait_reset_release("warm reset");
						gp_model = '0;
						check_value(gp_o, '0, "gp_o after warm reset");
					end else if (kind == "poweroff") begin
						run_access(OP_WRITE, '0, 32'd1, 4'hf, rd);
						// stays off until the board reset
						repeat (4 * 2 ** RST_BITS) begin
							check_value(sys_rst_o, 1'b1, "sys_rst_o while powered off");
							@(negedge clk_w);
						end
						rst_p = 1'b1;
						repeat (3) @(negedge clk_w);
						rst_p = 1'b0;
						wait_reset_release("rst_p after power-off");
						gp_model = '0;
						check_value(gp_o, '0, "gp_o after power-off");
					end else begin
						stop_run($sformatf("unknown reset kind %s in the trace", kind));
					end
				end
				default: stop_run($sformatf("unknown trace command %s", cmd));
			endcase
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: hdl/soc_top.sv
/*
 * System-control top level: bus decoder, device table, reset sequencer,
 * GPIO, scratch RAM and the activity indicator on a single clock.
 */
`timescale 1ns/1ps

module soc_top #(
	parameter int GPIOCOUNT = 8,
	parameter int RST_CNTR_BITSZ = 16,
	parameter int ACTIVITY_CNTR_BITSZ = 7
) (
	input logic clk_w,
	input logic rst_p,
	input soc_bus_pkg::bus_op_e pi1_op_i,
	input soc_bus_pkg::bus_addr_t pi1_addr_i,
	input soc_bus_pkg::bus_data_t pi1_data_i,
	input soc_bus_pkg::bus_sel_t pi1_sel_i,
	output soc_bus_pkg::bus_data_t pi1_data_o,
	output logic pi1_rdy_o,
	input logic [GPIOCOUNT-1:0] gp_i,
	output logic [GPIOCOUNT-1:1] gp_o,
	output logic sys_rst_o,
	output logic activity_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic sys_rst;
	rstreq_t rstreq;

	// one entry per register slave, the invalid slave lives in the decoder
	bus_op_e slv_op [SLV_INVALID];
	bus_addr_t slv_addr [SLV_INVALID];
	bus_data_t slv_data [SLV_INVALID];
	logic slv_rdy [SLV_INVALID];

	bus_decoder decoder (
		.clk_w(clk_w),
		.rst_i(sys_rst),
		.op_i(pi1_op_i),
		.addr_i(pi1_addr_i),
		.data_o(pi1_data_o),
		.rdy_o(pi1_rdy_o),
		.slv_op_o(slv_op),
		.slv_addr_o(slv_addr),
		.slv_data_i(slv_data),
		.slv_rdy_i(slv_rdy)
	);

	dev_table devtbl (
		.clk_w(clk_w),
		.rst_i(sys_rst),
		.op_i(slv_op[SLV_DEVTBL]),
		.addr_i(slv_addr[SLV_DEVTBL]),
		.data_i(pi1_data_i),
		.data_o(slv_data[SLV_DEVTBL]),
		.rdy_o(slv_rdy[SLV_DEVTBL]),
		.rstreq_o(rstreq)
	);

	reset_seq #(
		.RST_CNTR_BITSZ(RST_CNTR_BITSZ)
	) rstseq (
		.clk_w(clk_w),
		.rst_p(rst_p),
		.rstreq_i(rstreq),
		.sys_rst_o(sys_rst)
	);

	gpio_port #(
		.GPIOCOUNT(GPIOCOUNT)
	) gpio (
		.clk_w(clk_w),
		.rst_i(sys_rst),
		.op_i(slv_op[SLV_GPIO]),
		.addr_i(slv_addr[SLV_GPIO]),
		.data_i(pi1_data_i),
		.sel_i(pi1_sel_i),
		.data_o(slv_data[SLV_GPIO]),
		.rdy_o(slv_rdy[SLV_GPIO]),
		.gp_i(gp_i),
		.gp_o(gp_o)
	);

	scratch_ram ram (
		.clk_w(clk_w),
		.rst_i(sys_rst),
		.op_i(slv_op[SLV_RAM]),
		.addr_i(slv_addr[SLV_RAM]),
		.data_i(pi1_data_i),
		.sel_i(pi1_sel_i),
		.data_o(slv_data[SLV_RAM]),
		.rdy_o(slv_rdy[SLV_RAM])
	);

	// any completed transfer blinks the indicator
	activity_led #(
		.ACTIVITY_CNTR_BITSZ(ACTIVITY_CNTR_BITSZ)
	) led (
		.clk_w(clk_w),
		.rst_i(sys_rst),
		.xfer_i(pi1_rdy_o),
		.activity_o(activity_o)
	);

	assign sys_rst_o = sys_rst;

endmodule

// File: hdl/activity_led.sv
/*
 * Activity indicator: one-cycle pulse per transfer, dimmed by a hold-off counter.
 */
`timescale 1ns/1ps

module activity_led #(
	parameter int ACTIVITY_CNTR_BITSZ = 7
) (
	input logic clk_w,
	input logic rst_i,
	input logic xfer_i,
	output logic activity_o
);

	logic [ACTIVITY_CNTR_BITSZ-1:0] hold_cntr;
	logic act_q;

	// transfers seen during hold-off are ignored
	always_ff @(posedge clk_w) begin
		if (rst_i) begin
			hold_cntr <= '0;
			act_q <= 1'b0;
		end else if (hold_cntr != '0) begin
			hold_cntr <= hold_cntr - 1'b1;
			act_q <= 1'b0;
		end else if (xfer_i) begin
			hold_cntr <= '1;
			act_q <= 1'b1;
		end else begin
			act_q <= 1'b0;
		end
	end

	assign activity_o = act_q;

endmodule

// File: hdl/scratch_ram.sv
/*
 * On-chip scratch RAM in the RAM slot, byte-enabled writes and whole-word reads.
 */
`timescale 1ns/1ps

module scratch_ram (
	input logic clk_w,
	input logic rst_i,
	input soc_bus_pkg::bus_op_e op_i,
	input soc_bus_pkg::bus_addr_t addr_i,
	input soc_bus_pkg::bus_data_t data_i,
	input soc_bus_pkg::bus_sel_t sel_i,
	output soc_bus_pkg::bus_data_t data_o,
	output logic rdy_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int AW = $clog2(MAPSZ_RAM);

	bus_data_t mem [MAPSZ_RAM];
	bus_data_t data_q;
	logic start;
	logic rdy_q;
	logic [AW-1:0] idx;

	assign start = op_i != OP_NOP && !rdy_q;
	assign idx = addr_i[AW-1:0];

	always_ff @(posedge clk_w) begin
		if (rst_i)
			rdy_q <= 1'b0;
		else
			rdy_q <= start;
	end

	// contents survive a system reset
	always_ff @(posedge clk_w) begin
		if (start && op_i == OP_WRITE) begin
			for (int i = 0; i < SELBITSZ; i++) begin
				if (sel_i[i])
					mem[idx][8*i +: 8] <= data_i[8*i +: 8];
			end
		end
		if (start && op_i == OP_READ)
			data_q <= mem[idx];
	end

	assign data_o = data_q;
	assign rdy_o = rdy_q;

endmodule

// File: hdl/gpio_port.sv
/*
 * GPIO slave: byte-enabled output register at offset 0, synchronized inputs at offset 1.
 */
`timescale 1ns/1ps

module gpio_port #(
	parameter int GPIOCOUNT = 8
) (
	input logic clk_w,
	input logic rst_i,
	input soc_bus_pkg::bus_op_e op_i,
	input soc_bus_pkg::bus_addr_t addr_i,
	input soc_bus_pkg::bus_data_t data_i,
	input soc_bus_pkg::bus_sel_t sel_i,
	output soc_bus_pkg::bus_data_t data_o,
	output logic rdy_o,
	input logic [GPIOCOUNT-1:0] gp_i,
	output logic [GPIOCOUNT-1:1] gp_o
);

	import soc_bus_pkg::*;

	logic start;
	logic rdy_q;
	logic [GPIOCOUNT-1:0] out_q;
	logic [GPIOCOUNT-1:0] sync1_q;
	logic [GPIOCOUNT-1:0] sync2_q;
	bus_data_t rd_word;
	bus_data_t data_q;

	assign start = op_i != OP_NOP && !rdy_q;

	// two-flop synchronizer on the pins
	always_ff @(posedge clk_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
	end

	always_comb begin
		case (addr_i)
			bus_addr_t'(0): rd_word = bus_data_t'(out_q);
			bus_addr_t'(1): rd_word = bus_data_t'(sync2_q);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_w) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
			out_q <= '0;
		end else begin
			rdy_q <= start;
			if (start && op_i == OP_WRITE && addr_i == '0) begin
				for (int b = 0; b < GPIOCOUNT; b++) begin
					if (sel_i[b / 8])
						out_q[b] <= data_i[b];
				end
			end
		end
	end

	always_ff @(posedge clk_w) begin
		if (start)
			data_q <= rd_word;
	end

	assign data_o = data_q;
	assign rdy_o = rdy_q;
	// bit 0 stays internal
	assign gp_o = out_q[GPIOCOUNT-1:1];

endmodule

// File: sysctl/reset_seq.sv
/*
 * System reset sequencer. Stretches rst_p and software reset requests
 * through a down counter and holds the power-off state until rst_p.
 */
`timescale 1ns/1ps

module reset_seq #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input logic clk_w,
	input logic rst_p,
	input soc_map_pkg::rstreq_t rstreq_i,
	output logic sys_rst_o
);

	logic rst0;
	logic rst1;
	logic swwarm;
	logic swcold;
	logic swpwroff;
	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic pwroff_q;

	assign rst0 = rstreq_i[0];
	assign rst1 = rstreq_i[1];

	assign swwarm = !rst0 && rst1;
	// cold reset behaves as a warm one here
	assign swcold = rst0 && rst1;
	assign swpwroff = rst0 && !rst1;

	always_ff @(posedge clk_w) begin
		if (rst_p || swwarm || swcold)
			rst_cntr <= '1;
		else if (rst_cntr != '0)
			rst_cntr <= rst_cntr - 1'b1;
	end

	// once powered off only the board reset brings the system back
	always_ff @(posedge clk_w) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (swpwroff)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o = (rst_cntr != '0) || pwroff_q;

endmodule

// File: sysctl/dev_table.sv
/*
 * Device table slave. Software reads the slave count, ids, interrupt flags
 * and slot sizes here; writing word 0 requests a warm reset or a power-off.
 */
`timescale 1ns/1ps

module dev_table (
	input logic clk_w,
	input logic rst_i,
	input soc_bus_pkg::bus_op_e op_i,
	input soc_bus_pkg::bus_addr_t addr_i,
	input soc_bus_pkg::bus_data_t data_i,
	output soc_bus_pkg::bus_data_t data_o,
	output logic rdy_o,
	output soc_map_pkg::rstreq_t rstreq_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam logic [7:0] DEVIDS [SLAVECOUNT] = '{
		DEVID_DEVTBL, DEVID_GPIO, DEVID_RAM, DEVID_INVALID
	};
	localparam bus_addr_t MAPSZS [SLAVECOUNT] = '{
		MAPSZ_DEVTBL, MAPSZ_GPIO, MAPSZ_RAM, MAPSZ_INVALID
	};

	logic start;
	logic rdy_q;
	bus_data_t data_q;
	bus_data_t tbl_word;
	slv_idx_t ent;
	rstreq_t rstreq_q;

	// rdy just given blocks a restart on the same op
	assign start = op_i != OP_NOP && !rdy_q;

	// word 0 is the count, then an id word and a size word per slave
	assign ent = slv_idx_t'((addr_i - 1'b1) >> 1);

	always_comb begin
		tbl_word = '0;
		if (addr_i == '0) begin
			tbl_word = bus_data_t'(SLAVECOUNT);
		end else if (addr_i <= bus_addr_t'(2 * SLAVECOUNT)) begin
			if (addr_i[0]) begin
				tbl_word = bus_data_t'(DEVIDS[ent]);
				tbl_word[ARCHBITSZ-1] = USEINTR_MASK[ent];
			end else begin
				tbl_word = bus_data_t'(MAPSZS[ent]);
			end
		end
	end

	always_ff @(posedge clk_w) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
			rstreq_q <= '0;
		end else begin
			rdy_q <= start;
			if (start && op_i == OP_WRITE && addr_i == '0)
				rstreq_q <= rstreq_t'(data_i);
		end
	end

	always_ff @(posedge clk_w) begin
		if (start)
			data_q <= tbl_word;
	end

	assign data_o = data_q;
	assign rdy_o = rdy_q;
	assign rstreq_o = rstreq_q;

endmodule

// File: hdl/bus_decoder.sv
/*
 * Single-master bus decoder. Routes op to the slave whose slot holds the
 * address, muxes rdy and read data back, and answers unmapped addresses itself.
 */
`timescale 1ns/1ps

module bus_decoder (
	input logic clk_w,
	input logic rst_i,
	input soc_bus_pkg::bus_op_e op_i,
	input soc_bus_pkg::bus_addr_t addr_i,
	output soc_bus_pkg::bus_data_t data_o,
	output logic rdy_o,
	output soc_bus_pkg::bus_op_e slv_op_o [soc_map_pkg::SLV_INVALID],
	output soc_bus_pkg::bus_addr_t slv_addr_o [soc_map_pkg::SLV_INVALID],
	input soc_bus_pkg::bus_data_t slv_data_i [soc_map_pkg::SLV_INVALID],
	input logic slv_rdy_i [soc_map_pkg::SLV_INVALID]
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam bus_addr_t BASES [SLV_INVALID] = '{BASE_DEVTBL, BASE_GPIO, BASE_RAM};
	localparam bus_addr_t SIZES [SLV_INVALID] = '{MAPSZ_DEVTBL, MAPSZ_GPIO, MAPSZ_RAM};

	slv_idx_t cur_idx;
	slv_idx_t resp_idx_q;
	logic inv_rdy;

	// anything outside the packed slots falls to the invalid slave
	always_comb begin
		cur_idx = SLV_INVALID;
		for (int k = 0; k < SLV_INVALID; k++) begin
			if (addr_i >= BASES[k] && addr_i < BASES[k] + SIZES[k])
				cur_idx = slv_idx_t'(k);
		end
	end

	// no slave sees an op while the system is held in reset
	always_comb begin
		for (int k = 0; k < SLV_INVALID; k++) begin
			slv_addr_o[k] = addr_i - BASES[k];
			if (!rst_i && cur_idx == slv_idx_t'(k))
				slv_op_o[k] = op_i;
			else
				slv_op_o[k] = OP_NOP;
		end
	end

	// invalid slave acks at once, writes are dropped
	assign inv_rdy = !rst_i && cur_idx == SLV_INVALID && op_i != OP_NOP;

	// remember which register slave owns the access in flight
	always_ff @(posedge clk_w) begin
		if (rst_i)
			resp_idx_q <= SLV_DEVTBL;
		else if (op_i != OP_NOP && cur_idx != SLV_INVALID)
			resp_idx_q <= cur_idx;
	end

	always_comb begin
		if (cur_idx == SLV_INVALID) begin
			rdy_o = inv_rdy;
			data_o = '0;
		end else begin
			rdy_o = slv_rdy_i[resp_idx_q];
			data_o = slv_data_i[resp_idx_q];
		end
	end

endmodule

// File: common/soc_map_pkg.sv
/*
 * Address map of the system-control slice: slave order, slot sizes, bases and device ids.
 */
package soc_map_pkg;

	typedef logic [1:0] slv_idx_t;

	// slaves in address order, the invalid slave catches the rest
	localparam slv_idx_t SLV_DEVTBL = 2'd0;
	localparam slv_idx_t SLV_GPIO = 2'd1;
	localparam slv_idx_t SLV_RAM = 2'd2;
	localparam slv_idx_t SLV_INVALID = 2'd3;

	localparam int SLAVECOUNT = 4;

	// slot sizes in words
	localparam soc_bus_pkg::bus_addr_t MAPSZ_DEVTBL = 30'd64;
	localparam soc_bus_pkg::bus_addr_t MAPSZ_GPIO = 30'd4;
	localparam soc_bus_pkg::bus_addr_t MAPSZ_RAM = 30'd256;
	localparam soc_bus_pkg::bus_addr_t MAPSZ_INVALID = 30'd1024;

	// slots are packed one after another from word 0
	localparam soc_bus_pkg::bus_addr_t BASE_DEVTBL = 30'd0;
	localparam soc_bus_pkg::bus_addr_t BASE_GPIO = BASE_DEVTBL + MAPSZ_DEVTBL;
	localparam soc_bus_pkg::bus_addr_t BASE_RAM = BASE_GPIO + MAPSZ_GPIO;
	localparam soc_bus_pkg::bus_addr_t MAP_END = BASE_RAM + MAPSZ_RAM;

	// ids reported in the device table
	localparam logic [7:0] DEVID_DEVTBL = 8'd7;
	localparam logic [7:0] DEVID_GPIO = 8'd6;
	localparam logic [7:0] DEVID_RAM = 8'd1;
	localparam logic [7:0] DEVID_INVALID = 8'd0;

	// bit k set when slave k raises interrupts, only the GPIO does
	localparam logic [SLAVECOUNT-1:0] USEINTR_MASK = 4'b0010;

	// software reset request, bit 0 is rst0 and bit 1 is rst1
	typedef logic [1:0] rstreq_t;

endpackage

// File: common/soc_bus_pkg.sv
/*
 * Peripheral bus definitions shared by the master port, the decoder and every slave.
 */
package soc_bus_pkg;

	// data path width in bits
	localparam int ARCHBITSZ = 32;

	// word address width, the byte offset bits are not carried
	localparam int ADDRBITSZ = 30;

	// one byte enable per data byte
	localparam int SELBITSZ = ARCHBITSZ / 8;

	typedef logic [ARCHBITSZ-1:0] bus_data_t;

	typedef logic [ADDRBITSZ-1:0] bus_addr_t;

	typedef logic [SELBITSZ-1:0] bus_sel_t;

	// bus operation driven by the master
	// code 3 was a swap on the full bus and is not used here
	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ = 2'd2
	} bus_op_e;

endpackage
